// ==== common/reg_disp_defs.svh ====
`ifndef REG_DISP_DEFS_SVH
`define REG_DISP_DEFS_SVH

// native register bus widths
`define REG_DISP_ADDR_WIDTH 64
`define REG_DISP_DATA_WIDTH 32

// map_1 plus three shared maps
`define REG_DISP_NUM_TARGETS 4

// map_1 window 0x000 to 0x117
`define REG_DISP_MAP1_SLICE 9
`define REG_DISP_MAP1_LAST_WORD 'h45

// shared windows, 16 bytes each
`define REG_DISP_SHARED_WORDS 4
`define REG_DISP_SHARED0_BASE 64'h120
`define REG_DISP_SHARED1_BASE 64'h130
`define REG_DISP_SHARED2_BASE 64'h140

`endif

// ==== common/reg_disp_pkg.sv ====
`include "reg_disp_defs.svh"

package reg_disp_pkg;

    // byte address as seen on the native bus
    typedef logic [`REG_DISP_ADDR_WIDTH-1:0] disp_addr_t;

    // register payload
    typedef logic [`REG_DISP_DATA_WIDTH-1:0] disp_data_t;

    // destination of a request
    // child values double as the index into the response vectors
    typedef enum logic [2:0] {
        tgt_map_1    = 3'd0,
        tgt_shared_0 = 3'd1,
        tgt_shared_1 = 3'd2,
        tgt_shared_2 = 3'd3,
        tgt_none     = 3'd4
    } disp_target_e;

endpackage

// ==== common/disp_req_if.sv ====
`timescale 1ns/1ns
`include "reg_disp_defs.svh"

interface disp_req_if import reg_disp_pkg::*; ();

    logic         req_vld;
    disp_target_e target;
    disp_addr_t   addr;
    logic         wr_en;
    logic         rd_en;
    disp_data_t   wr_data;

    modport decoder (
        output req_vld,
        output target,
        output addr,
        output wr_en,
        output rd_en,
        output wr_data
    );

    modport forward (
        input req_vld,
        input target,
        input addr,
        input wr_en,
        input rd_en,
        input wr_data
    );

    // only needs to spot the dummy register case
    modport backward (
        input req_vld,
        input target
    );

endinterface

// ==== common/disp_rsp_if.sv ====
`timescale 1ns/1ns
`include "reg_disp_defs.svh"

interface disp_rsp_if import reg_disp_pkg::*; ();

    // one entry per child, indexed like disp_target_e
    logic [`REG_DISP_NUM_TARGETS-1:0]             ack_vld;
    logic [`REG_DISP_NUM_TARGETS-1:0]             err;
    disp_data_t [`REG_DISP_NUM_TARGETS-1:0]       rd_data;

    modport backward (
        input ack_vld,
        input err,
        input rd_data
    );

endinterface

// ==== reg_disp/reg_disp_decoder.sv ====
`timescale 1ns/1ns
`include "reg_disp_defs.svh"

module reg_disp_decoder import reg_disp_pkg::*; (
    input  logic       req_vld,
    input  disp_addr_t addr,
    input  logic       wr_en,
    input  logic       rd_en,
    input  disp_data_t wr_data,
    disp_req_if.decoder req
);

    logic [`REG_DISP_ADDR_WIDTH-3:0] word_addr;

    // true when the word address falls in a shared window
    function automatic logic in_shared(
        input logic [`REG_DISP_ADDR_WIDTH-3:0] word,
        input disp_addr_t                      base
    );
        logic [`REG_DISP_ADDR_WIDTH-3:0] base_word;
        base_word = base[`REG_DISP_ADDR_WIDTH-1:2];
        return (word >= base_word) && (word < base_word + `REG_DISP_SHARED_WORDS);
    endfunction

    // byte lanes are ignored for the decode
    assign word_addr = addr[`REG_DISP_ADDR_WIDTH-1:2];

    always_comb begin
        if (word_addr <= `REG_DISP_MAP1_LAST_WORD) begin
            req.target = tgt_map_1;
        end else if (in_shared(word_addr, `REG_DISP_SHARED0_BASE)) begin
            req.target = tgt_shared_0;
        end else if (in_shared(word_addr, `REG_DISP_SHARED1_BASE)) begin
            req.target = tgt_shared_1;
        end else if (in_shared(word_addr, `REG_DISP_SHARED2_BASE)) begin
            req.target = tgt_shared_2;
        end else begin
            // falls through to the dummy register
            req.target = tgt_none;
        end
    end

    // request fields pass straight through
    assign req.req_vld = req_vld;
    assign req.addr    = addr;
    assign req.wr_en   = wr_en;
    assign req.rd_en   = rd_en;
    assign req.wr_data = wr_data;

endmodule

// ==== reg_disp/reg_disp_forward.sv ====
`timescale 1ns/1ns
`include "reg_disp_defs.svh"

module reg_disp_forward import reg_disp_pkg::*; (
    input  logic                                  root_map_clk,
    input  logic                                  root_map_rst_n,
    disp_req_if.forward                           req,
    input  logic                                  soft_rst,
    output logic [`REG_DISP_NUM_TARGETS-1:0]       tgt_req_vld,
    output disp_addr_t [`REG_DISP_NUM_TARGETS-1:0] tgt_addr,
    output logic [`REG_DISP_NUM_TARGETS-1:0]       tgt_wr_en,
    output logic [`REG_DISP_NUM_TARGETS-1:0]       tgt_rd_en,
    output disp_data_t [`REG_DISP_NUM_TARGETS-1:0] tgt_wr_data,
    output logic [`REG_DISP_NUM_TARGETS-1:0]       tgt_soft_rst
);

    logic [`REG_DISP_NUM_TARGETS-1:0] hit;
    disp_addr_t                       conv_addr;

    // one-hot slot select, only while a request is live
    always_comb begin
        for (int i = 0; i < `REG_DISP_NUM_TARGETS; i++) begin
            hit[i] = req.req_vld && (int'(req.target) == i);
        end
    end

    // absolute address to child offset
    always_comb begin
        case (req.target)
            tgt_map_1: begin
                // window is aligned, so slicing is enough
                conv_addr = {
                    {(`REG_DISP_ADDR_WIDTH - `REG_DISP_MAP1_SLICE){1'b0}},
                    req.addr[`REG_DISP_MAP1_SLICE-1:0]
                };
            end
            tgt_shared_0: begin
                conv_addr = req.addr - `REG_DISP_SHARED0_BASE;
            end
            tgt_shared_1: begin
                conv_addr = req.addr - `REG_DISP_SHARED1_BASE;
            end
            tgt_shared_2: begin
                conv_addr = req.addr - `REG_DISP_SHARED2_BASE;
            end
            default: begin
                conv_addr = '0;
            end
        endcase
    end

    // forward register stage
    always_ff @(posedge root_map_clk or negedge root_map_rst_n) begin
        if (!root_map_rst_n) begin
            tgt_req_vld  <= '0;
            tgt_addr     <= '0;
            tgt_wr_en    <= '0;
            tgt_rd_en    <= '0;
            tgt_wr_data  <= '0;
            tgt_soft_rst <= '0;
        end else begin
            for (int i = 0; i < `REG_DISP_NUM_TARGETS; i++) begin
                // unselected slots stay at zero
                tgt_req_vld[i] <= hit[i];
                tgt_addr[i]    <= hit[i] ? conv_addr : '0;
                tgt_wr_en[i]   <= hit[i] & req.wr_en;
                tgt_rd_en[i]   <= hit[i] & req.rd_en;
                tgt_wr_data[i] <= hit[i] ? req.wr_data : '0;
            end
            // soft reset goes to every child
            tgt_soft_rst <= {`REG_DISP_NUM_TARGETS{soft_rst}};
        end
    end

endmodule

// ==== reg_disp/reg_disp_backward.sv ====
`timescale 1ns/1ns
`include "reg_disp_defs.svh"

module reg_disp_backward import reg_disp_pkg::*; (
    input  logic        root_map_clk,
    input  logic        root_map_rst_n,
    disp_req_if.backward req,
    disp_rsp_if.backward rsp,
    output logic        ack_vld,
    output logic        err,
    output disp_data_t  rd_data
);

    logic       miss;
    logic       ack_vld_nxt;
    logic       err_nxt;
    disp_data_t rd_data_nxt;

    // dummy register answers the same cycle it is hit
    assign miss = req.req_vld && (req.target == tgt_none);

    assign ack_vld_nxt = (|rsp.ack_vld) | miss;
    assign err_nxt     = (|rsp.err) | miss;

    // data from whichever child acks, zero for the dummy
    always_comb begin
        rd_data_nxt = '0;
        if (!miss) begin
            for (int i = 0; i < `REG_DISP_NUM_TARGETS; i++) begin
                if (rsp.ack_vld[i]) begin
                    rd_data_nxt = rsp.rd_data[i];
                end
            end
        end
    end

    // backward register stage
    always_ff @(posedge root_map_clk or negedge root_map_rst_n) begin
        if (!root_map_rst_n) begin
            ack_vld <= 1'b0;
            err     <= 1'b0;
            rd_data <= '0;
        end else begin
            ack_vld <= ack_vld_nxt;
            err     <= err_nxt;
            rd_data <= rd_data_nxt;
        end
    end

endmodule

// ==== src/reg_disp_root.sv ====
`timescale 1ns/1ns
`include "reg_disp_defs.svh"

module reg_disp_root import reg_disp_pkg::*; (
    input  logic       root_map_clk,
    input  logic       root_map_rst_n,
    // upstream requester
    input  logic       root_map_req_vld,
    input  disp_addr_t root_map_addr,
    input  logic       root_map_wr_en,
    input  logic       root_map_rd_en,
    input  disp_data_t root_map_wr_data,
    input  logic       root_map_soft_rst,
    output logic       root_map_ack_vld,
    output logic       root_map_err,
    output disp_data_t root_map_rd_data,
    // map_1
    output logic       map_1_req_vld,
    output disp_addr_t map_1_addr,
    output logic       map_1_wr_en,
    output logic       map_1_rd_en,
    output disp_data_t map_1_wr_data,
    output logic       map_1_soft_rst,
    input  logic       map_1_ack_vld,
    input  logic       map_1_err,
    input  disp_data_t map_1_rd_data,
    // shared_map_0
    output logic       shared_map_0_req_vld,
    output disp_addr_t shared_map_0_addr,
    output logic       shared_map_0_wr_en,
    output logic       shared_map_0_rd_en,
    output disp_data_t shared_map_0_wr_data,
    output logic       shared_map_0_soft_rst,
    input  logic       shared_map_0_ack_vld,
    input  logic       shared_map_0_err,
    input  disp_data_t shared_map_0_rd_data,
    // shared_map_1
    output logic       shared_map_1_req_vld,
    output disp_addr_t shared_map_1_addr,
    output logic       shared_map_1_wr_en,
    output logic       shared_map_1_rd_en,
    output disp_data_t shared_map_1_wr_data,
    output logic       shared_map_1_soft_rst,
    input  logic       shared_map_1_ack_vld,
    input  logic       shared_map_1_err,
    input  disp_data_t shared_map_1_rd_data,
    // shared_map_2
    output logic       shared_map_2_req_vld,
    output disp_addr_t shared_map_2_addr,
    output logic       shared_map_2_wr_en,
    output logic       shared_map_2_rd_en,
    output disp_data_t shared_map_2_wr_data,
    output logic       shared_map_2_soft_rst,
    input  logic       shared_map_2_ack_vld,
    input  logic       shared_map_2_err,
    input  disp_data_t shared_map_2_rd_data
);

    disp_req_if req_if ();
    disp_rsp_if rsp_if ();

    // child responses packed in target index order
    assign rsp_if.ack_vld = {shared_map_2_ack_vld, shared_map_1_ack_vld,
                             shared_map_0_ack_vld, map_1_ack_vld};
    assign rsp_if.err     = {shared_map_2_err, shared_map_1_err, shared_map_0_err, map_1_err};
    assign rsp_if.rd_data = {shared_map_2_rd_data, shared_map_1_rd_data,
                             shared_map_0_rd_data, map_1_rd_data};

    reg_disp_decoder reg_disp_decoder_inst (
        .req_vld (root_map_req_vld),
        .addr    (root_map_addr),
        .wr_en   (root_map_wr_en),
        .rd_en   (root_map_rd_en),
        .wr_data (root_map_wr_data),
        .req     (req_if.decoder)
    );

    reg_disp_forward reg_disp_forward_inst (
        .root_map_clk   (root_map_clk),
        .root_map_rst_n (root_map_rst_n),
        .req            (req_if.forward),
        .soft_rst       (root_map_soft_rst),
        .tgt_req_vld    ({shared_map_2_req_vld, shared_map_1_req_vld,
                          shared_map_0_req_vld, map_1_req_vld}),
        .tgt_addr       ({shared_map_2_addr, shared_map_1_addr,
                          shared_map_0_addr, map_1_addr}),
        .tgt_wr_en      ({shared_map_2_wr_en, shared_map_1_wr_en,
                          shared_map_0_wr_en, map_1_wr_en}),
        .tgt_rd_en      ({shared_map_2_rd_en, shared_map_1_rd_en,
                          shared_map_0_rd_en, map_1_rd_en}),
        .tgt_wr_data    ({shared_map_2_wr_data, shared_map_1_wr_data,
                          shared_map_0_wr_data, map_1_wr_data}),
        .tgt_soft_rst   ({shared_map_2_soft_rst, shared_map_1_soft_rst,
                          shared_map_0_soft_rst, map_1_soft_rst})
    );

    reg_disp_backward reg_disp_backward_inst (
        .root_map_clk   (root_map_clk),
        .root_map_rst_n (root_map_rst_n),
        .req            (req_if.backward),
        .rsp            (rsp_if.backward),
        .ack_vld        (root_map_ack_vld),
        .err            (root_map_err),
        .rd_data        (root_map_rd_data)
    );

endmodule

// ==== bench/tb_reg_disp_root.sv ====
`timescale 1ns/1ns
`include "reg_disp_defs.svh"

module tb_reg_disp_root;

    localparam int NUM_ENTRIES = 13;
    localparam int NO_TARGET   = 4;

    logic        root_map_clk;
    logic        root_map_rst_n;
    logic        req_vld;
    logic [63:0] addr;
    logic        wr_en;
    logic        rd_en;
    logic [31:0] wr_data;
    logic        soft_rst;
    logic        ack_vld;
    logic        err;
    logic [31:0] rd_data;

    // child side, indexed like the target select
    logic [3:0]  c_req_vld;
    logic [63:0] c_addr [4];
    logic [3:0]  c_wr_en;
    logic [3:0]  c_rd_en;
    logic [31:0] c_wr_data [4];
    logic [3:0]  c_soft_rst;
    logic [3:0]  c_ack_vld;
    logic [3:0]  c_err;
    logic [31:0] c_rd_data [4];

    // stimulus table
    logic [63:0] t_addr [NUM_ENTRIES];
    logic        t_wr [NUM_ENTRIES];
    logic [31:0] t_wdata [NUM_ENTRIES];
    int          t_tgt [NUM_ENTRIES];
    logic [63:0] t_caddr [NUM_ENTRIES];
    logic        t_err [NUM_ENTRIES];
    int          n_entries;

    reg_disp_root reg_disp_root_inst (
        .root_map_clk(root_map_clk), .root_map_rst_n(root_map_rst_n),
        .root_map_req_vld(req_vld), .root_map_addr(addr), .root_map_wr_en(wr_en),
        .root_map_rd_en(rd_en), .root_map_wr_data(wr_data), .root_map_soft_rst(soft_rst),
        .root_map_ack_vld(ack_vld), .root_map_err(err), .root_map_rd_data(rd_data),
        .map_1_req_vld(c_req_vld[0]), .map_1_addr(c_addr[0]), .map_1_wr_en(c_wr_en[0]),
        .map_1_rd_en(c_rd_en[0]), .map_1_wr_data(c_wr_data[0]),
        .map_1_soft_rst(c_soft_rst[0]), .map_1_ack_vld(c_ack_vld[0]),
        .map_1_err(c_err[0]), .map_1_rd_data(c_rd_data[0]),
        .shared_map_0_req_vld(c_req_vld[1]), .shared_map_0_addr(c_addr[1]),
        .shared_map_0_wr_en(c_wr_en[1]), .shared_map_0_rd_en(c_rd_en[1]),
        .shared_map_0_wr_data(c_wr_data[1]), .shared_map_0_soft_rst(c_soft_rst[1]),
        .shared_map_0_ack_vld(c_ack_vld[1]), .shared_map_0_err(c_err[1]),
        .shared_map_0_rd_data(c_rd_data[1]),
        .shared_map_1_req_vld(c_req_vld[2]), .shared_map_1_addr(c_addr[2]),
        .shared_map_1_wr_en(c_wr_en[2]), .shared_map_1_rd_en(c_rd_en[2]),
        .shared_map_1_wr_data(c_wr_data[2]), .shared_map_1_soft_rst(c_soft_rst[2]),
        .shared_map_1_ack_vld(c_ack_vld[2]), .shared_map_1_err(c_err[2]),
        .shared_map_1_rd_data(c_rd_data[2]),
        .shared_map_2_req_vld(c_req_vld[3]), .shared_map_2_addr(c_addr[3]),
        .shared_map_2_wr_en(c_wr_en[3]), .shared_map_2_rd_en(c_rd_en[3]),
        .shared_map_2_wr_data(c_wr_data[3]), .shared_map_2_soft_rst(c_soft_rst[3]),
        .shared_map_2_ack_vld(c_ack_vld[3]), .shared_map_2_err(c_err[3]),
        .shared_map_2_rd_data(c_rd_data[3])
    );

    initial begin
        root_map_clk = 1'b0;
        forever #5 root_map_clk = ~root_map_clk;
    end

    initial begin
        #((NUM_ENTRIES * 10 + 50) * 10);
        $display("simulation timed out before all table entries completed");
        $display("TEST FAILED");
        $fatal(1);
    end

    // responder read data: child index on top, child address below
    function automatic logic [31:0] responder_data(input int idx, input logic [63:0] caddr);
        logic [3:0] idx_bits;
        idx_bits = idx[3:0];
        return {idx_bits, caddr[27:0]};
    endfunction

    function automatic string child_name(input int idx);
        string names [4];
        names = '{"map_1", "shared_map_0", "shared_map_1", "shared_map_2"};
        return names[idx];
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic add_entry(input logic [63:0] a, input logic wr, input int tgt,
                             input logic [63:0] caddr, input logic e);
        t_addr[n_entries]  = a;
        t_wr[n_entries]    = wr;
        t_wdata[n_entries] = $urandom;
        t_tgt[n_entries]   = tgt;
        t_caddr[n_entries] = caddr;
        t_err[n_entries]   = e;
        n_entries++;
    endtask

    // one responder per child, acks 1 to 3 cycles after its request
    for (genvar g = 0; g < 4; g++) begin : responder
        initial begin
            int unsigned delay;
            logic [63:0] seen_addr;
            logic        seen_wr;
            c_ack_vld[g] = 1'b0;
            c_err[g]     = 1'b0;
            c_rd_data[g] = '0;
            forever begin
                @(posedge root_map_clk);
                if (c_req_vld[g]) begin
                    seen_addr = c_addr[g];
                    seen_wr   = c_wr_en[g];
                    delay     = $urandom_range(3, 1);
                    repeat (delay - 1) @(posedge root_map_clk);
                    c_ack_vld[g] <= 1'b1;
                    c_err[g]     <= seen_wr && (seen_addr == 64'hC);
                    c_rd_data[g] <= responder_data(g, seen_addr);
                    @(posedge root_map_clk);
                    c_ack_vld[g] <= 1'b0;
                    c_err[g]     <= 1'b0;
                    c_rd_data[g] <= '0;
                end
            end
        end
    end

    initial begin
        int  seed_ret;
        int  tgt;
        bit  found;
        seed_ret = $urandom(32'he057f126);
        root_map_rst_n = 1'b0;
        req_vld  = 1'b0;
        addr     = '0;
        wr_en    = 1'b0;
        rd_en    = 1'b0;
        wr_data  = '0;
        soft_rst = 1'b0;
        n_entries = 0;
        // window edges and the three base subtractions
        add_entry(64'h000, 1'b0, 0, 64'h000, 1'b0);
        add_entry(64'h104, 1'b1, 0, 64'h104, 1'b0);
        add_entry(64'h117, 1'b0, 0, 64'h117, 1'b0);
        add_entry(64'h10C, 1'b1, 0, 64'h10C, 1'b0);
        add_entry(64'h120, 1'b0, 1, 64'h000, 1'b0);
        add_entry(64'h12C, 1'b1, 1, 64'h00C, 1'b1);
        add_entry(64'h13C, 1'b0, 2, 64'h00C, 1'b0);
        add_entry(64'h13C, 1'b1, 2, 64'h00C, 1'b1);
        add_entry(64'h140, 1'b1, 3, 64'h000, 1'b0);
        add_entry(64'h14F, 1'b0, 3, 64'h00F, 1'b0);
        // misses go to the dummy register
        add_entry(64'h118, 1'b0, NO_TARGET, 64'h0, 1'b1);
        add_entry(64'h150, 1'b1, NO_TARGET, 64'h0, 1'b1);
        add_entry(64'h1_0000_0120, 1'b0, NO_TARGET, 64'h0, 1'b1);

        repeat (3) @(posedge root_map_clk);
        root_map_rst_n <= 1'b1;
        @(negedge root_map_clk);
        check_value("child req_vld", c_req_vld, 0);
        check_value("child wr_en", c_wr_en, 0);
        check_value("child rd_en", c_rd_en, 0);
        check_value("child soft_rst", c_soft_rst, 0);
        check_value("root_map_ack_vld", ack_vld, 0);
        check_value("root_map_err", err, 0);

        for (int k = 0; k < n_entries; k++) begin
            tgt = t_tgt[k];
            @(posedge root_map_clk);
            req_vld <= 1'b1;
            addr    <= t_addr[k];
            wr_en   <= t_wr[k];
            rd_en   <= !t_wr[k];
            wr_data <= t_wdata[k];
            @(posedge root_map_clk);
            req_vld <= 1'b0;
            wr_en   <= 1'b0;
            rd_en   <= 1'b0;
            @(negedge root_map_clk);
            for (int i = 0; i < 4; i++) begin
                check_value($sformatf("%s_req_vld", child_name(i)), c_req_vld[i], i == tgt);
            end
            if (tgt == NO_TARGET) begin
                check_value("root_map_ack_vld", ack_vld, 1);
                check_value("root_map_err", err, 1);
                check_value("root_map_rd_data", rd_data, 0);
            end else begin
                check_value($sformatf("%s_addr", child_name(tgt)), c_addr[tgt], t_caddr[k]);
                check_value($sformatf("%s_wr_data", child_name(tgt)), c_wr_data[tgt],
                            t_wdata[k]);
                check_value($sformatf("%s_wr_en", child_name(tgt)), c_wr_en[tgt], t_wr[k]);
                check_value($sformatf("%s_rd_en", child_name(tgt)), c_rd_en[tgt], !t_wr[k]);
                check_value("root_map_ack_vld", ack_vld, 0);
                found = 1'b0;
                for (int n = 0; n < 8 && !found; n++) begin
                    @(negedge root_map_clk);
                    if (c_ack_vld[tgt]) begin
                        found = 1'b1;
                    end else begin
                        check_value("root_map_ack_vld", ack_vld, 0);
                    end
                end
                if (!found) begin
                    $display("child %s never acknowledged its request", child_name(tgt));
                    $display("TEST FAILED");
                    $fatal(1);
                end
                // upstream answer lags the child ack by one cycle
                @(negedge root_map_clk);
                check_value("root_map_ack_vld", ack_vld, 1);
                check_value("root_map_err", err, t_err[k]);
                if (!t_wr[k]) begin
                    check_value("root_map_rd_data", rd_data, responder_data(tgt, t_caddr[k]));
                end
            end
        end

        @(posedge root_map_clk);
        soft_rst <= 1'b1;
        @(posedge root_map_clk);
        soft_rst <= 1'b0;
        @(negedge root_map_clk);
        check_value("child soft_rst", c_soft_rst, 4'hF);
        @(negedge root_map_clk);
        check_value("child soft_rst", c_soft_rst, 4'h0);

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+common
common/reg_disp_pkg.sv
common/disp_req_if.sv
common/disp_rsp_if.sv
reg_disp/reg_disp_decoder.sv
reg_disp/reg_disp_forward.sv
reg_disp/reg_disp_backward.sv
src/reg_disp_root.sv
bench/tb_reg_disp_root.sv
